// File: list.f
logic/uart_pkg.sv
logic/uart_rx.sv
logic/rx_merge.sv
logic/uart_dual_rx.sv
verification/rx_checker.sv
verification/tb_uart_dual_rx.sv

// File: logic/rx_merge.sv
////////////////////////////////////////////////////////////////////////////
// Two-channel byte merge.
// Acknowledges ready receivers, channel 0 first, tags each byte with its
// channel and framing error, queues it and flags overrun when full.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
module rx_merge
  import uart_pkg::*;
#(
  parameter int fifo_depth = 4      // Entries, power of two.
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rdy_0,      // Channel 0 has a byte.
  input  logic              rdy_1,      // Channel 1 has a byte.
  input  rx_byte_t          data_0,
  input  rx_byte_t          data_1,
  input  logic              err_0,
  input  logic              err_1,
  output logic              clr_rdy_0,  // Byte taken from channel 0.
  output logic              clr_rdy_1,  // Byte taken from channel 1.
  input  logic              out_pop,    // Remove head entry.
  output logic              out_valid,  // FIFO not empty.
  output rx_byte_t          out_data,
  output logic [chan_w-1:0] out_chan,
  output logic              out_err,
  output logic              overrun     // Sticky, a byte was dropped.
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam logic [ptr_w:0] depth_cnt = (ptr_w + 1)'(fifo_depth);

  ////////////////////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////////////////////
  logic [entry_w-1:0] fifo_mem [fifo_depth];  // Entry storage.
  logic [ptr_w-1:0]   wr_ptr;                 // Next free slot.
  logic [ptr_w-1:0]   rd_ptr;                 // Head slot.
  logic [ptr_w:0]     count;                  // Entries held.
  logic               take_0;                 // Serve channel 0.
  logic               take_1;                 // Serve channel 1.
  logic               push;                   // A byte is acknowledged.
  logic               full;
  logic               wr_en;                  // Byte is stored.
  logic               rd_en;                  // Head is removed.
  rx_byte_t           in_data;
  logic               in_err;
  logic [chan_w-1:0]  in_chan;
  logic [entry_w-1:0] in_entry;
  logic [entry_w-1:0] head;

  // Fixed priority, channel 1 waits one cycle on a tie.
  assign take_0 = rdy_0;
  assign take_1 = rdy_1 & ~rdy_0;
  assign push   = take_0 | take_1;

  assign clr_rdy_0 = take_0;        // Same cycle as the capture.
  assign clr_rdy_1 = take_1;

  // Build the tagged entry.
  assign in_data  = take_1 ? data_1 : data_0;
  assign in_err   = take_1 ? err_1 : err_0;
  assign in_chan  = take_1 ? chan_w'(1) : chan_w'(0);
  assign in_entry = {in_chan, in_err, in_data};

  ////////////////////////////////////////////////////////////////////////////
  // Circular FIFO
  ////////////////////////////////////////////////////////////////////////////
  assign full      = (count == depth_cnt);
  assign out_valid = (count != '0);
  assign wr_en     = push & ~full;  // Full drops the byte.
  assign rd_en     = out_pop & out_valid; // Pop on empty is ignored.

  always_ff @(posedge clk) begin
    if (wr_en)
      fifo_mem[wr_ptr] <= in_entry;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;    // Wraps at the power of two.
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (ptr_w + 1)'(wr_en) - (ptr_w + 1)'(rd_en);
    end
  end

  // Head entry fields.
  assign head     = fifo_mem[rd_ptr];
  assign out_data = head[data_w-1:0];
  assign out_err  = head[ent_err_bit];
  assign out_chan = head[ent_chan_lsb +: chan_w];

  // Stays set until reset.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      overrun <= 1'b0;
    else if (push && full)
      overrun <= 1'b1;
  end

  // One receiver acknowledged per cycle.
  one_clr_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
    !(clr_rdy_0 && clr_rdy_1))
    else $error("rx_merge: both receivers acknowledged together");

  // Occupancy bound.
  count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= depth_cnt)
    else $error("rx_merge: FIFO count above depth");

endmodule

// File: logic/uart_dual_rx.sv
////////////////////////////////////////////////////////////////////////////
// Dual UART receive front end, top level.
// Two receivers at separate baud rates feeding one tagged byte queue.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
module uart_dual_rx
  import uart_pkg::*;
#(
  parameter int baud_div_0 = 2604,  // Clocks per bit, channel 0.
  parameter int baud_div_1 = 2604,  // Clocks per bit, channel 1.
  parameter int fifo_depth = 4      // Queue entries.
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rx_0,       // Serial line, channel 0.
  input  logic              rx_1,       // Serial line, channel 1.
  input  logic              out_pop,    // Consumer takes the head.
  output logic              out_valid,  // Head entry present.
  output rx_byte_t          out_data,
  output logic [chan_w-1:0] out_chan,
  output logic              out_err,    // Head had a framing error.
  output logic              overrun     // A byte was lost.
);

  // Receiver to merge links.
  logic     rdy_0;
  logic     rdy_1;
  logic     clr_rdy_0;
  logic     clr_rdy_1;
  rx_byte_t data_0;
  rx_byte_t data_1;
  logic     err_0;
  logic     err_1;

  uart_rx #(.baud_div(baud_div_0)) rx_ch0_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx_0),
    .clr_rdy   (clr_rdy_0),
    .rx_data   (data_0),
    .frame_err (err_0),
    .rdy       (rdy_0)
  );

  uart_rx #(.baud_div(baud_div_1)) rx_ch1_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx_1),
    .clr_rdy   (clr_rdy_1),
    .rx_data   (data_1),
    .frame_err (err_1),
    .rdy       (rdy_1)
  );

  // Arbitration, tagging and queueing.
  rx_merge #(.fifo_depth(fifo_depth)) rx_merge_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdy_0     (rdy_0),
    .rdy_1     (rdy_1),
    .data_0    (data_0),
    .data_1    (data_1),
    .err_0     (err_0),
    .err_1     (err_1),
    .clr_rdy_0 (clr_rdy_0),
    .clr_rdy_1 (clr_rdy_1),
    .out_pop   (out_pop),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_chan  (out_chan),
    .out_err   (out_err),
    .overrun   (overrun)
  );

endmodule

// File: logic/uart_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Dual-channel UART receive front end, shared definitions.
// Byte width, channel count and the layout of one FIFO entry.
////////////////////////////////////////////////////////////////////////////
package uart_pkg;

  // Received byte.
  localparam int data_w = 8;        // Bits per serial byte.
  typedef logic [data_w-1:0] rx_byte_t;

  // Channels.
  localparam int num_chan = 2;                  // Independent RX lines.
  localparam int chan_w   = $clog2(num_chan);   // Width of the channel tag.

  ////////////////////////////////////////////////////////////////////////////
  // FIFO entry layout, LSB first: byte, framing error, channel tag.
  ////////////////////////////////////////////////////////////////////////////
  localparam int ent_err_bit  = data_w;             // Framing error position.
  localparam int ent_chan_lsb = data_w + 1;         // Channel tag starts here.
  localparam int entry_w      = data_w + 1 + chan_w; // Whole entry, 10 bits.

endpackage

// File: logic/uart_rx.sv
////////////////////////////////////////////////////////////////////////////
// Single-channel UART receiver.
// 8N1 frames sampled at mid-bit, stop bit checked for framing error,
// rdy held until acknowledged or the next start bit arrives.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
module uart_rx
  import uart_pkg::*;
#(
  parameter int baud_div = 2604     // Clocks per bit.
) (
  input  logic     clk,             // System clock.
  input  logic     rst_n,           // Async active low reset.
  input  logic     rx,              // Serial line, idles high.
  input  logic     clr_rdy,         // Knocks down rdy.
  output rx_byte_t rx_data,         // Last byte received.
  output logic     frame_err,       // Stop bit of that byte was low.
  output logic     rdy              // Byte available.
);

  localparam int cnt_w = $clog2(baud_div);                  // Baud counter width.
  localparam logic [cnt_w-1:0] half_load = cnt_w'(baud_div / 2 - 1); // To mid start bit.
  localparam logic [cnt_w-1:0] full_load = cnt_w'(baud_div - 1);     // Bit to bit.
  localparam logic [3:0] last_bit = 4'd9;  // Samples taken before the stop bit.

  typedef enum logic {IDLE, RCV} state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////////////////////
  logic             rx_meta;        // First synchronizer stage.
  logic             rx_stable;      // Second synchronizer stage.
  logic             rx_last;        // Previous rx_stable, for edge detect.
  logic             rx_fall;        // Falling edge on the synced line.
  logic [data_w:0]  rx_shft_reg;    // Data bits plus stop bit.
  logic [cnt_w-1:0] baud_cnt;       // Clocks left until the next sample.
  logic [3:0]       bit_cnt;        // Samples taken in this frame.
  logic             start;          // Begin a frame.
  logic             shift;          // Sample point reached.
  logic             receiving;      // FSM is in a frame.
  logic             set_rdy;        // Frame complete.
  state_t           state;
  state_t           nxt_state;

  // Double flop the line, keep one more stage to see the edge.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_meta   <= 1'b1;            // Line idles high.
      rx_stable <= 1'b1;
      rx_last   <= 1'b1;
    end else begin
      rx_meta   <= rx;
      rx_stable <= rx_meta;
      rx_last   <= rx_stable;
    end
  end

  // A low stop bit leaves the line low, so only a real edge starts a frame.
  assign rx_fall = rx_last & ~rx_stable;

  // Shift in LSB first, the start bit falls out of the bottom.
  always_ff @(posedge clk) begin
    if (shift)
      rx_shft_reg <= {rx_stable, rx_shft_reg[data_w:1]};
  end

  // Half a period to the middle of the start bit, then full periods.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (start)
      baud_cnt <= half_load;        // Aim at mid start bit.
    else if (shift)
      baud_cnt <= full_load;        // Next mid bit.
    else if (receiving)
      baud_cnt <= baud_cnt - 1'b1;
  end

  // Samples taken so far.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= 4'd0;
    else if (start)
      bit_cnt <= 4'd0;
    else if (shift)
      bit_cnt <= bit_cnt + 4'd1;
  end

  assign receiving = (state == RCV);
  assign shift     = receiving && (baud_cnt == '0);

  assign rx_data   = rx_shft_reg[data_w-1:0];   // Eight data bits.
  assign frame_err = ~rx_shft_reg[data_w];      // Stop bit must be high.

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM and ready flag
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;              // Hold by default.
    start     = 1'b0;
    set_rdy   = 1'b0;
    case (state)
      RCV: begin
        if (shift && (bit_cnt == last_bit)) begin
          set_rdy   = 1'b1;         // Stop bit sampled this cycle.
          nxt_state = IDLE;
        end
      end
      default: begin                // IDLE, wait for a start edge.
        if (rx_fall) begin
          start     = 1'b1;
          nxt_state = RCV;
        end
      end
    endcase
  end

  // Start clears, frame end sets, acknowledge clears.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rdy <= 1'b0;
    else if (start)
      rdy <= 1'b0;                  // Next byte is on its way.
    else if (set_rdy)
      rdy <= 1'b1;
    else if (clr_rdy)
      rdy <= 1'b0;
  end

  // An acknowledge must never meet the end of a new frame.
  rdy_not_set_on_clr: assert property (@(posedge clk) disable iff (!rst_n)
    clr_rdy |=> !rdy)
    else $error("uart_rx: rdy set while clr_rdy was high");

  // Ten samples per frame at most.
  bit_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    bit_cnt <= 4'd10)
    else $error("uart_rx: bit counter passed ten");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the dual UART receiver testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_uart_dual_rx \
  -f list.f \
  -o tb_uart_dual_rx

status=0
result=$(./obj_dir/tb_uart_dual_rx 2>&1) || status=$?
echo "$result"

if [ "$status" -eq 0 ] && echo "$result" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// File: verification/rx_checker.sv
////////////////////////////////////////////////////////////////////////////
// Scoreboard for the dual UART receive front end.
// Keeps the expected bytes per channel, checks every popped entry and the
// overrun flag, reports each test and the totals.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
module rx_checker
  import uart_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              out_pop,      // Watched DUT ports.
  input  logic              out_valid,
  input  rx_byte_t          out_data,
  input  logic [chan_w-1:0] out_chan,
  input  logic              out_err,
  input  logic              overrun,
  input  logic              exp_push,     // Queue one expected entry.
  input  logic [chan_w-1:0] exp_chan,
  input  rx_byte_t          exp_data,
  input  logic              exp_err,
  input  logic              exp_ovr,      // Overrun expected by now.
  input  logic [7:0]        exp_test,     // Test in progress.
  input  logic              test_done,    // That test has drained.
  input  logic              all_done,     // Print the totals.
  output int                error_count
);

  logic [data_w:0] exp_q0 [$];   // {err, data} still due on channel 0.
  logic [data_w:0] exp_q1 [$];   // Same for channel 1.
  int              errs;
  int              checked;
  int              test_errs;
  int              test_pops;
  int              tests;

  initial begin
    errs      = 0;
    checked   = 0;
    test_errs = 0;
    test_pops = 0;
    tests     = 0;
  end

  assign error_count = errs;

  task automatic count_error();
    errs++;
    test_errs++;
  endtask

  always @(posedge clk) begin : scoreboard
    logic [data_w:0] head;
    logic            found;
    head  = '0;
    found = 1'b0;
    if (exp_push) begin
      if (exp_chan == '0)
        exp_q0.push_back({exp_err, exp_data});
      else
        exp_q1.push_back({exp_err, exp_data});
    end

    // Nothing outstanding, so the queue must be empty.
    if (rst_n && out_valid && exp_q0.size() == 0 && exp_q1.size() == 0) begin
      $display("CHECK FAILED at %0d ns: out_valid = %b, expected %b", $time, out_valid, 1'b0);
      count_error();
    end

    ////////////////////////////////////////////////////////////////////////
    // Head entry leaves the queue.
    ////////////////////////////////////////////////////////////////////////
    if (rst_n && out_pop && out_valid) begin
      if (out_chan == '0 && exp_q0.size() > 0) begin
        head  = exp_q0.pop_front();
        found = 1'b1;
      end else if (out_chan != '0 && exp_q1.size() > 0) begin
        head  = exp_q1.pop_front();
        found = 1'b1;
      end
      if (!found) begin
        $display("At %0d ns byte %h came out on channel %0d, none was expected there",
                 $time, out_data, out_chan);
        count_error();
      end else begin
        if (out_data !== head[data_w-1:0]) begin
          $display("CHECK FAILED at %0d ns: out_data = %h, expected %h",
                   $time, out_data, head[data_w-1:0]);
          count_error();
        end
        if (out_err !== head[data_w]) begin
          $display("CHECK FAILED at %0d ns: out_err = %b, expected %b",
                   $time, out_err, head[data_w]);
          count_error();
        end
      end
      if (overrun !== exp_ovr) begin
        $display("CHECK FAILED at %0d ns: overrun = %b, expected %b", $time, overrun, exp_ovr);
        count_error();
      end
      checked++;
      test_pops++;
    end

    // Test drained, nothing may be left over.
    if (test_done) begin
      if (overrun !== exp_ovr) begin
        $display("CHECK FAILED at %0d ns: overrun = %b, expected %b", $time, overrun, exp_ovr);
        count_error();
      end
      if (exp_q0.size() != 0) begin
        $display("Test %0d: %0d byte(s) for channel 0 were never delivered",
                 exp_test, exp_q0.size());
        count_error();
        exp_q0.delete();
      end
      if (exp_q1.size() != 0) begin
        $display("Test %0d: %0d byte(s) for channel 1 were never delivered",
                 exp_test, exp_q1.size());
        count_error();
        exp_q1.delete();
      end
      $display("Test %0d finished: %0d entries checked, %0d errors",
               exp_test, test_pops, test_errs);
      tests++;
      test_pops = 0;
      test_errs = 0;
    end

    if (all_done)
      $display("Totals: %0d tests, %0d entries checked, %0d errors", tests, checked, errs);
  end

endmodule

// File: verification/tb_uart_dual_rx.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the dual UART receive front end.
// Replays frames from the stim file on both RX lines, pops the queue at
// random intervals and leaves the scoring to rx_checker.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
module tb_uart_dual_rx
  import uart_pkg::*;
();

  localparam int baud_0     = 16;   // Clocks per bit, channel 0.
  localparam int baud_1     = 24;   // Clocks per bit, channel 1.
  localparam int fifo_depth = 4;
  localparam int max_items  = 32;   // Room for stim lines.
  localparam int stim_cols  = 6;    // Words per stim line.

  logic              clk;
  logic              rst_n;
  logic              rx_0;
  logic              rx_1;
  logic              out_pop;
  logic              out_valid;
  rx_byte_t          out_data;
  logic [chan_w-1:0] out_chan;
  logic              out_err;
  logic              overrun;
  logic              exp_push;      // Expected entry towards the checker.
  logic [chan_w-1:0] exp_chan;
  rx_byte_t          exp_data;
  logic              exp_err;
  logic              exp_ovr;
  logic [7:0]        exp_test;
  logic              test_done;
  logic              all_done;
  int                error_count;

  logic [7:0]        stim_mem [max_items*stim_cols];  // Raw stim words.
  logic [7:0]        item_test [max_items];
  logic [chan_w-1:0] item_chan [max_items];
  rx_byte_t          item_data [max_items];
  logic              item_stop [max_items];
  logic              item_ovl  [max_items];           // Starts with the next item.
  logic              item_hold [max_items];           // No pops during the test.
  int                n_items;
  int                cycle_limit;
  int                cycles;
  int                held_cnt;                        // Bytes sent while popping is held.
  logic              hold_pops;
  logic [31:0]       lfsr;

  uart_dual_rx #(
    .baud_div_0 (baud_0),
    .baud_div_1 (baud_1),
    .fifo_depth (fifo_depth)
  ) uart_dual_rx_inst (
    .clk (clk), .rst_n (rst_n), .rx_0 (rx_0), .rx_1 (rx_1), .out_pop (out_pop),
    .out_valid (out_valid), .out_data (out_data), .out_chan (out_chan),
    .out_err (out_err), .overrun (overrun)
  );

  rx_checker checker_inst (
    .clk (clk), .rst_n (rst_n), .out_pop (out_pop), .out_valid (out_valid),
    .out_data (out_data), .out_chan (out_chan), .out_err (out_err), .overrun (overrun),
    .exp_push (exp_push), .exp_chan (exp_chan), .exp_data (exp_data), .exp_err (exp_err),
    .exp_ovr (exp_ovr), .exp_test (exp_test), .test_done (test_done),
    .all_done (all_done), .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;         // 100 ns period.
  end

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two fresh bits give 0 to 3 cycles.
  task automatic pick_pop_delay(output int d);
    logic [1:0] bits;
    bits = '0;
    repeat (2) begin
      lfsr = next_lfsr(lfsr);
      bits = {bits[0], lfsr[0]};
    end
    d = int'(bits);
  endtask

  task automatic set_line(input logic [chan_w-1:0] chan, input logic v);
    if (chan == '0)
      rx_0 = v;
    else
      rx_1 = v;
  endtask

  // Start bit, data LSB first, given stop bit, then two idle bits.
  task automatic send_frame(input int idx);
    int                baud;
    int                b;
    logic [chan_w-1:0] chan;
    chan = item_chan[idx];
    baud = (chan == '0) ? baud_0 : baud_1;
    set_line(chan, 1'b0);
    repeat (baud) @(negedge clk);
    for (b = 0; b < data_w; b++) begin
      set_line(chan, item_data[idx][b]);
      repeat (baud) @(negedge clk);
    end
    set_line(chan, item_stop[idx]);
    repeat (baud) @(negedge clk);
    set_line(chan, 1'b1);
    repeat (2 * baud) @(negedge clk);
  endtask

  // A full FIFO drops the byte, so only overrun is expected for it.
  task automatic expect_entry(input int idx);
    if (hold_pops && held_cnt >= fifo_depth) begin
      exp_ovr = 1'b1;
    end else begin
      exp_chan = item_chan[idx];
      exp_data = item_data[idx];
      exp_err  = ~item_stop[idx];   // Low stop bit is a framing error.
      exp_push = 1'b1;
      @(negedge clk);
      exp_push = 1'b0;
    end
    held_cnt++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Consumer and run limit
  ////////////////////////////////////////////////////////////////////////////
  initial begin : popper
    int pop_wait;
    out_pop = 1'b0;
    lfsr    = 32'h7947;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (out_valid && !hold_pops) begin
        pick_pop_delay(pop_wait);
        repeat (pop_wait) @(negedge clk);
        out_pop = 1'b1;
        @(negedge clk);
        out_pop = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles without reaching its end", cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int         i;
    int         k;
    logic [7:0] cur_test;
    rx_0      = 1'b1;               // Lines idle high.
    rx_1      = 1'b1;
    rst_n     = 1'b0;
    hold_pops = 1'b0;
    exp_push  = 1'b0;
    exp_chan  = '0;
    exp_data  = '0;
    exp_err   = 1'b0;
    exp_ovr   = 1'b0;
    exp_test  = '0;
    test_done = 1'b0;
    all_done  = 1'b0;
    held_cnt  = 0;
    for (k = 0; k < max_items * stim_cols; k++)
      stim_mem[k] = 8'h00;
    $readmemh("verification/uart_stim.txt", stim_mem);
    for (k = 0; k < max_items; k++) begin
      item_test[k] = stim_mem[k*stim_cols];
      item_chan[k] = stim_mem[k*stim_cols + 1][chan_w-1:0];
      item_data[k] = stim_mem[k*stim_cols + 2];
      item_stop[k] = stim_mem[k*stim_cols + 3][0];
      item_ovl[k]  = stim_mem[k*stim_cols + 4][0];
      item_hold[k] = stim_mem[k*stim_cols + 5][0];
    end
    n_items = 0;
    while (n_items < max_items && item_test[n_items] != 8'h00)
      n_items++;
    cycle_limit = n_items * 12 * baud_1 + 500;   // Longest frame plus gap per item.
    if (n_items == 0)
      $display("No test items could be read from the stim file");
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // One block per test number.
    i = 0;
    while (i < n_items) begin
      cur_test  = item_test[i];
      exp_test  = cur_test;
      hold_pops = item_hold[i];
      held_cnt  = 0;
      while (i < n_items && item_test[i] == cur_test) begin
        if (item_ovl[i] && i + 1 < n_items) begin
          expect_entry(i);
          expect_entry(i + 1);
          fork
            send_frame(i);
            send_frame(i + 1);
          join
          i += 2;
        end else begin
          expect_entry(i);
          send_frame(i);
          i++;
        end
      end
      hold_pops = 1'b0;
      while (out_valid)             // Drain the queue.
        @(negedge clk);
      repeat (2) @(negedge clk);
      test_done = 1'b1;
      @(negedge clk);
      test_done = 1'b0;
    end

    all_done = 1'b1;
    @(negedge clk);
    all_done = 1'b0;
    if (error_count == 0 && n_items > 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verification/uart_stim.txt
// Columns (hex): test, channel, data byte, stop bit, overlap, pop hold.
// Overlap items come in pairs that start together; test 00 ends the list.
01 0 a5 1 0 0
01 1 3c 1 0 0
02 0 5a 0 0 0
02 1 c3 0 0 0
02 0 7e 1 0 0
03 0 11 1 1 0
03 1 22 1 1 0
03 0 33 0 1 0
03 1 44 1 1 0
03 0 55 1 0 0
04 0 01 1 0 0
04 0 02 1 0 0
04 1 81 1 0 0
04 0 03 1 0 0
04 1 82 1 0 0
04 1 83 1 0 0
04 0 04 1 0 0
05 0 f0 1 0 1
05 1 f1 1 0 1
05 0 f2 1 0 1
05 1 f3 1 0 1
05 0 f4 1 0 1
05 1 f5 1 0 1
06 1 99 1 0 0
06 0 66 0 0 0
00 0 00 0 0 0
